// ==== Makefile ====
# Verilator build and run of the stream buffer testbench.
# Any variable below can be overridden, e.g. make test OBJ_DIR=build

VERILATOR ?= verilator
TOP ?= stream_buffer_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps -j 0
PASS_MSG ?= All tests passed

SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_MSG"

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass only when the run prints the pass line.
test: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/stream_buffer_tb.sv ====
`timescale 1ns/1ps
`include "stream_cfg.svh"

module stream_buffer_tb import stream_pkg::*; ();

	localparam int clk_period = 8;
	localparam int beats_per_scan = `SB_ROWS * `SB_CHANNELS * `SB_WINDOW;
	localparam int max_records = 64;

	logic clk;
	logic reset;
	bank_wr_t ddr_wr;
	fill_wr_t fill_wr;
	logic start_req;
	logic start_ack;
	feat_beat_t beat;

	int unsigned wr_count;
	logic wr_bank [max_records];
	bank_addr_t wr_addr [max_records];
	feat_word_t wr_word [max_records];
	feat_word_t wr_other [max_records];
	logic wr_sel [max_records];
	int unsigned exp_count;
	feat_word_t exp_word0 [max_records];
	feat_word_t exp_word1 [max_records];
	feat_word_t b1_sel_word [`SB_DEPTH];   // bank 1 as written.
	feat_word_t b1_other_word [`SB_DEPTH];

	feat_word_t got_word0 [$];
	feat_word_t got_word1 [$];
	logic got_last [$];
	int got_cycle [$];
	bit last_seen;
	int cycle = 0;
	int start_cycle;
	int errors;
	int test_err_start;
	int tests_run;
	int tests_failed;

	stream_buffer_top dut (
		.clk(clk),
		.i_reset(reset),
		.i_ddr_wr(ddr_wr),
		.i_fill_wr(fill_wr),
		.i_start_req(start_req),
		.o_start_ack(start_ack),
		.o_beat(beat)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// beat capture, well clear of the edge.
	always @(posedge clk) begin
		#2;
		if (beat.valid) begin
			got_word0.push_back(beat.word0);
			got_word1.push_back(beat.word1);
			got_last.push_back(beat.last);
			got_cycle.push_back(cycle);
			if (beat.last) begin
				last_seen = 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic load_testdata(output bit ok);
		int fd;
		int n;
		string line;
		logic [31:0] f0, f1, f2, f3, f4;
		ok = 1'b0;
		wr_count = 0;
		exp_count = 0;
		fd = $fopen("dv/stream_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/stream_testdata.txt");
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0) begin
				continue;   // nothing read at end of file.
			end
			if ($sscanf(line, "W %h %h %h %h %h", f0, f1, f2, f3, f4) == 5) begin
				if (wr_count < max_records) begin
					wr_bank[wr_count] = f0[0];
					wr_addr[wr_count] = f1[`SB_ADDR_W-1:0];
					wr_word[wr_count] = f2[`SB_DATA_W-1:0];
					wr_other[wr_count] = f3[`SB_DATA_W-1:0];
					wr_sel[wr_count] = f4[0];
					wr_count++;
				end
			end else if ($sscanf(line, "E %h %h", f0, f1) == 2) begin
				if (exp_count < max_records) begin
					exp_word0[exp_count] = f0[`SB_DATA_W-1:0];
					exp_word1[exp_count] = f1[`SB_DATA_W-1:0];
					exp_count++;
				end
			end
		end
		$fclose(fd);
		ok = (wr_count > 0) && (exp_count > 0);
	endtask

	task automatic write_banks();
		int i;
		for (i = 0; i < wr_count; i++) begin
			ddr_wr = '0;
			fill_wr = '0;
			if (wr_bank[i] == 1'b0) begin
				ddr_wr.en = 1'b1;
				ddr_wr.addr = wr_addr[i];
				ddr_wr.data = wr_word[i];
			end else begin
				fill_wr.en = 1'b1;
				fill_wr.addr = wr_addr[i];
				fill_wr.eltwise_sel = wr_sel[i];
				fill_wr.eltwise = wr_sel[i] ? wr_word[i] : wr_other[i];
				fill_wr.pool = wr_sel[i] ? wr_other[i] : wr_word[i];
				b1_sel_word[wr_addr[i]] = wr_word[i];
				b1_other_word[wr_addr[i]] = wr_other[i];
			end
			step();
		end
		ddr_wr = '0;
		fill_wr = '0;
	endtask

	task automatic clear_capture();
		got_word0.delete();
		got_word1.delete();
		got_last.delete();
		got_cycle.delete();
		last_seen = 1'b0;
	endtask

	// row outer, position middle, word inner.
	function automatic int scan_addr(input int idx);
		int w;
		int p;
		int r;
		w = idx % `SB_WINDOW;
		p = (idx / `SB_WINDOW) % `SB_CHANNELS;
		r = idx / (`SB_WINDOW * `SB_CHANNELS);
		return r * `SB_ROW_STRIDE + p + w;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic handshake(input int hold);
		int n;
		start_req = 1'b1;
		step();
		n = 0;
		while (!start_ack && n < 10) begin
			step();
			n++;
		end
		start_cycle = cycle;
		if (!start_ack) begin
			$display("timed out waiting for the start ack to rise");
			errors++;
		end else if (n != 0) begin
			$display("FAIL %0t: start ack rose %0d cycles late", $time, n);
			errors++;
		end
		repeat (hold) begin
			step();
			if (!start_ack) begin
				$display("FAIL %0t: start ack dropped while request held", $time);
				errors++;
			end
		end
		start_req = 1'b0;
		step();
		n = 0;
		while (start_ack && n < 10) begin
			step();
			n++;
		end
		if (start_ack) begin
			$display("timed out waiting for the start ack to fall");
			errors++;
		end else if (n != 0) begin
			$display("FAIL %0t: start ack fell %0d cycles late", $time, n);
			errors++;
		end
	endtask

	task automatic wait_scan_end();
		int n;
		n = 0;
		while (!last_seen && got_word0.size() < beats_per_scan && n < 100) begin
			step();
			n++;
		end
		if (!last_seen && got_word0.size() < beats_per_scan) begin
			$display("timed out waiting for the scan to finish");
			errors++;
		end
	endtask

	task automatic check_words();
		int i;
		if (got_word0.size() != beats_per_scan || exp_count != beats_per_scan) begin
			$display("FAIL %0t: %0d beats, expected %0d (%0d E records)", $time,
				got_word0.size(), beats_per_scan, exp_count);
			errors++;
		end
		// first beat lands four bank cycles after the first address.
		if (got_cycle.size() > 0 && got_cycle[0] != start_cycle + `SB_RD_LAT + 1) begin
			$display("FAIL %0t: first beat at cycle %0d, expected %0d", $time,
				got_cycle[0], start_cycle + `SB_RD_LAT + 1);
			errors++;
		end
		for (i = 0; i < got_word0.size() && i < exp_count; i++) begin
			if (got_word0[i] !== exp_word0[i] || got_word1[i] !== exp_word1[i]) begin
				$display("FAIL %0t: beat %0d words %h %h, expected %h %h", $time, i,
					got_word0[i], got_word1[i], exp_word0[i], exp_word1[i]);
				errors++;
			end
			if (got_cycle[i] != got_cycle[0] + i) begin
				$display("FAIL %0t: gap before beat %0d", $time, i);
				errors++;
			end
		end
	endtask

	task automatic check_bank1_source();
		int i;
		int a;
		if (got_word1.size() == 0) begin
			$display("FAIL %0t: no beats to check bank 1 source", $time);
			errors++;
		end
		for (i = 0; i < got_word1.size(); i++) begin
			a = scan_addr(i);
			if (got_word1[i] !== b1_sel_word[a]) begin
				$display("FAIL %0t: beat %0d bank 1 word %h, selected source had %h", $time,
					i, got_word1[i], b1_sel_word[a]);
				errors++;
			end
			if (got_word1[i] === b1_other_word[a]) begin
				$display("FAIL %0t: beat %0d carries the unselected word %h", $time, i,
					got_word1[i]);
				errors++;
			end
		end
	endtask

	task automatic check_last();
		int i;
		if (!last_seen) begin
			$display("FAIL %0t: no beat carried last", $time);
			errors++;
		end
		for (i = 0; i < got_last.size(); i++) begin
			if (got_last[i] != (i == beats_per_scan - 1)) begin
				$display("FAIL %0t: beat %0d last flag %b", $time, i, got_last[i]);
				errors++;
			end
		end
		repeat (`SB_RD_LAT + 2) begin
			if (beat.valid) begin
				$display("FAIL %0t: valid still high after the last beat", $time);
				errors++;
			end
			step();
		end
	endtask

	task automatic begin_test();
		test_err_start = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_err_start) begin
			$display("test %0d %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - test_err_start);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_tests();
		begin_test();
		repeat (20) begin
			step();
			if (start_ack || beat.valid) begin
				$display("FAIL %0t: ack %b valid %b before any request", $time,
					start_ack, beat.valid);
				errors++;
			end
		end
		end_test("reset idle");
		write_banks();
		clear_capture();
		begin_test();
		handshake(3);   // scan runs meanwhile.
		end_test("start handshake");
		begin_test();
		wait_scan_end();
		check_words();
		end_test("fill and scan");
		begin_test();
		check_bank1_source();
		end_test("bank 1 source select");
		begin_test();
		check_last();
		end_test("last flag");
		clear_capture();
		begin_test();
		handshake(1);
		wait_scan_end();
		check_words();
		check_last();
		end_test("repeat scan");
	endtask

	initial begin
		bit ok;
		reset = 1'b1;
		ddr_wr = '0;
		fill_wr = '0;
		start_req = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		last_seen = 1'b0;
		load_testdata(ok);
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		if (!ok) begin
			$display("test data missing or empty, no tests were run");
			errors++;
		end else begin
			run_tests();
		end
		$display("tests run %0d, passed %0d, failed %0d, failed checks %0d", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== dv/stream_testdata.txt ====
# W bank addr word other sel : bank 1 puts word on the sel source, other on the unused one.
# E word0 word1 : expected bank 0 and bank 1 words of each scan beat, in order.
W 0 000 3c01 0000 0
W 0 001 3c12 0000 0
W 0 002 3c23 0000 0
W 0 003 3c34 0000 0
W 0 004 3c45 0000 0
W 0 005 3c56 0000 0
W 0 006 3c67 0000 0
W 0 007 3c78 0000 0
W 1 000 5a10 dead 0
W 1 001 6b21 beef 1
W 1 002 5a32 d00d 0
W 1 003 6b43 f00d 1
W 1 004 5a54 dead 0
W 1 005 6b65 beef 1
W 1 006 5a76 d00d 0
W 1 007 6b87 f00d 1
# addresses 0 1 1 2 2 3 then 4 5 5 6 6 7.
E 3c01 5a10
E 3c12 6b21
E 3c12 6b21
E 3c23 5a32
E 3c23 5a32
E 3c34 6b43
E 3c45 5a54
E 3c56 6b65
E 3c56 6b65
E 3c67 5a76
E 3c67 5a76
E 3c78 6b87

// ==== flist.f ====
+incdir+rtl
rtl/stream_pkg.sv
rtl/fill_decode.sv
rtl/scan_address_gen.sv
rtl/feature_bank.sv
rtl/stream_result.sv
rtl/stream_buffer_top.sv
dv/stream_buffer_tb.sv

// ==== rtl/feature_bank.sv ====
`timescale 1ns/1ps
`include "stream_cfg.svh"

module feature_bank import stream_pkg::*; (
	input logic clk,
	input bank_wr_t i_wr,
	input bank_addr_t i_raddr,
	output feat_word_t o_rdata
);

	// raddr reg and ram read take two of the latency cycles.
	localparam int out_stages = `SB_RD_LAT - 2;

	feat_word_t mem [`SB_DEPTH];
	bank_addr_t raddr_q;
	feat_word_t ram_q;
	feat_word_t out_q [out_stages];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write port.
	always_ff @(posedge clk) begin
		if (i_wr.en) begin
			mem[i_wr.addr] <= i_wr.data;
		end
	end

	// read port.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
		ram_q <= mem[raddr_q];
	end

	always_ff @(posedge clk) begin
		out_q[0] <= ram_q;
		for (int i = 1; i < out_stages; i++) begin
			out_q[i] <= out_q[i-1];
		end
	end

	assign o_rdata = out_q[out_stages-1];

endmodule

// ==== rtl/fill_decode.sv ====
`timescale 1ns/1ps

module fill_decode import stream_pkg::*; (
	input logic clk,
	input logic i_reset,
	input bank_wr_t i_ddr_wr,
	input fill_wr_t i_fill_wr,
	input logic i_start_req,
	input logic i_scan_done,
	output logic o_start_ack,
	output logic o_scan_start,
	output bank_wr_t o_bank0_wr,
	output bank_wr_t o_bank1_wr
);

	start_state_e state_q;
	logic scan_busy_q;   // set at start, cleared by scan done.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// four-phase start handshake.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state_q <= st_idle;
			scan_busy_q <= 1'b0;
			o_scan_start <= 1'b0;
		end else begin
			o_scan_start <= 1'b0;
			if (i_scan_done) begin
				scan_busy_q <= 1'b0;
			end
			case (state_q)
				st_idle: begin
					if (i_start_req) begin
						state_q <= st_acked;
						scan_busy_q <= 1'b1;
						o_scan_start <= 1'b1;
					end
				end
				st_acked: begin
					if (!i_start_req) begin
						state_q <= st_running;   // ack drops here.
					end
				end
				st_running: begin
					// done may have come while ack was still up.
					if (!scan_busy_q || i_scan_done) begin
						state_q <= st_idle;
					end
				end
				default: begin
					state_q <= st_idle;
				end
			endcase
		end
	end

	assign o_start_ack = (state_q == st_acked);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write routing.
	assign o_bank0_wr = i_ddr_wr;

	always_comb begin
		o_bank1_wr.en = i_fill_wr.en;
		o_bank1_wr.addr = i_fill_wr.addr;
		if (i_fill_wr.eltwise_sel) begin
			o_bank1_wr.data = i_fill_wr.eltwise;
		end else begin
			o_bank1_wr.data = i_fill_wr.pool;
		end
	end

	// start pulse only as ack rises, and never with a scan outstanding.
	a_start_pulse: assert property (
		@(posedge clk) disable iff (i_reset)
		o_scan_start |-> o_start_ack && !$past(o_start_ack) && !$past(scan_busy_q)
	) else $error("scan start outside the idle to acked transition or during a scan");

endmodule

// ==== rtl/scan_address_gen.sv ====
`timescale 1ns/1ps
`include "stream_cfg.svh"

module scan_address_gen import stream_pkg::*; (
	input logic clk,
	input logic i_reset,
	input logic i_scan_start,
	output scan_rd_t o_rd,
	output logic o_scan_done
);

	localparam bank_addr_t word_last = bank_addr_t'(`SB_WINDOW - 1);
	localparam bank_addr_t pos_last = bank_addr_t'(`SB_CHANNELS - 1);
	localparam bank_addr_t row_last = bank_addr_t'(`SB_ROWS - 1);
	localparam bank_addr_t row_stride = bank_addr_t'(`SB_ROW_STRIDE);
	// single-step scan ends on its first address.
	localparam bit first_last = (word_last == '0) && (pos_last == '0) && (row_last == '0);

	bank_addr_t word_q, pos_q, row_q, base_q;
	bank_addr_t word_nxt, pos_nxt, row_nxt, base_nxt;
	logic last_nxt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next step: word inner, position middle, row outer.
	always_comb begin
		word_nxt = word_q;
		pos_nxt = pos_q;
		row_nxt = row_q;
		base_nxt = base_q;
		if (word_q != word_last) begin
			word_nxt = word_q + 1'b1;
		end else begin
			word_nxt = '0;
			if (pos_q != pos_last) begin
				pos_nxt = pos_q + 1'b1;
			end else begin
				pos_nxt = '0;
				row_nxt = row_q + 1'b1;
				base_nxt = base_q + row_stride;
			end
		end
	end

	assign last_nxt = (word_nxt == word_last) && (pos_nxt == pos_last) && (row_nxt == row_last);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_rd <= '0;
			o_scan_done <= 1'b0;
			word_q <= '0;
			pos_q <= '0;
			row_q <= '0;
			base_q <= '0;
		end else begin
			o_scan_done <= o_rd.valid && o_rd.last;
			if (o_rd.valid && !o_rd.last) begin
				word_q <= word_nxt;
				pos_q <= pos_nxt;
				row_q <= row_nxt;
				base_q <= base_nxt;
				o_rd.addr <= base_nxt + pos_nxt + word_nxt;
				o_rd.last <= last_nxt;
			end else if (i_scan_start) begin
				word_q <= '0;
				pos_q <= '0;
				row_q <= '0;
				base_q <= '0;
				o_rd.valid <= 1'b1;
				o_rd.addr <= '0;
				o_rd.last <= first_last;
			end else begin
				o_rd.valid <= 1'b0;   // idle or just past last.
				o_rd.last <= 1'b0;
			end
		end
	end

	// full-width step address, before any wrap to the bank address width.
	a_addr_range: assert property (
		@(posedge clk) disable iff (i_reset)
		o_rd.valid |-> (int'(row_q) * `SB_ROW_STRIDE + int'(pos_q) + int'(word_q) < `SB_DEPTH)
	) else $error("scan address beyond bank depth");

endmodule

// ==== rtl/stream_buffer_top.sv ====
`timescale 1ns/1ps

module stream_buffer_top import stream_pkg::*; (
	input logic clk,
	input logic i_reset,
	input bank_wr_t i_ddr_wr,
	input fill_wr_t i_fill_wr,
	input logic i_start_req,
	output logic o_start_ack,
	output feat_beat_t o_beat
);

	bank_wr_t bank0_wr;
	bank_wr_t bank1_wr;
	logic scan_start;
	logic scan_done;
	scan_rd_t scan_rd;
	feat_word_t word0;
	feat_word_t word1;

	fill_decode u_decode (
		.clk(clk),
		.i_reset(i_reset),
		.i_ddr_wr(i_ddr_wr),
		.i_fill_wr(i_fill_wr),
		.i_start_req(i_start_req),
		.i_scan_done(scan_done),
		.o_start_ack(o_start_ack),
		.o_scan_start(scan_start),
		.o_bank0_wr(bank0_wr),
		.o_bank1_wr(bank1_wr)
	);

	scan_address_gen u_scan (
		.clk(clk),
		.i_reset(i_reset),
		.i_scan_start(scan_start),
		.o_rd(scan_rd),
		.o_scan_done(scan_done)
	);

	// both banks read at the shared scan address.
	feature_bank u_bank0 (
		.clk(clk),
		.i_wr(bank0_wr),
		.i_raddr(scan_rd.addr),
		.o_rdata(word0)
	);

	feature_bank u_bank1 (
		.clk(clk),
		.i_wr(bank1_wr),
		.i_raddr(scan_rd.addr),
		.o_rdata(word1)
	);

	stream_result u_result (
		.clk(clk),
		.i_reset(i_reset),
		.i_rd(scan_rd),
		.i_word0(word0),
		.i_word1(word1),
		.o_beat(o_beat)
	);

endmodule

// ==== rtl/stream_cfg.svh ====
`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bank geometry.
`define SB_DATA_W 16
`define SB_ADDR_W 10
`define SB_DEPTH 1024

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scan shape.
`define SB_WINDOW 2      // words per window.
`define SB_CHANNELS 3    // window positions per row.
`define SB_ROWS 2
`define SB_ROW_STRIDE 4

// raddr reg + ram + output regs.
`define SB_RD_LAT 4

`endif

// ==== rtl/stream_pkg.sv ====
`include "stream_cfg.svh"

package stream_pkg;

	typedef logic [`SB_DATA_W-1:0] feat_word_t;
	typedef logic [`SB_ADDR_W-1:0] bank_addr_t;

	// plain bank write port.
	typedef struct packed {
		logic en;
		bank_addr_t addr;
		feat_word_t data;
	} bank_wr_t;

	// bank 1 fill, two candidate sources.
	typedef struct packed {
		logic en;
		bank_addr_t addr;
		feat_word_t pool;
		feat_word_t eltwise;
		logic eltwise_sel;   // 1 picks eltwise.
	} fill_wr_t;

	typedef struct packed {
		logic valid;
		logic last;
		bank_addr_t addr;
	} scan_rd_t;

	typedef struct packed {
		logic valid;
		logic last;
		feat_word_t word0;
		feat_word_t word1;
	} feat_beat_t;

	typedef enum logic [1:0] {
		st_idle,
		st_acked,
		st_running
	} start_state_e;

endpackage

// ==== rtl/stream_result.sv ====
`timescale 1ns/1ps
`include "stream_cfg.svh"

module stream_result import stream_pkg::*; (
	input logic clk,
	input logic i_reset,
	input scan_rd_t i_rd,
	input feat_word_t i_word0,
	input feat_word_t i_word1,
	output feat_beat_t o_beat
);

	// flags ride alongside the bank read pipeline.
	logic [`SB_RD_LAT-1:0] valid_sr;
	logic [`SB_RD_LAT-1:0] last_sr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// latency match.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_sr <= '0;
			last_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[`SB_RD_LAT-2:0], i_rd.valid};
			last_sr <= {last_sr[`SB_RD_LAT-2:0], i_rd.last};
		end
	end

	always_comb begin
		o_beat.valid = valid_sr[`SB_RD_LAT-1];
		o_beat.last = last_sr[`SB_RD_LAT-1];
		o_beat.word0 = i_word0;   // already aligned by the banks.
		o_beat.word1 = i_word1;
	end

	// generator must only flag last on a valid step.
	a_last_valid: assert property (
		@(posedge clk) disable iff (i_reset)
		o_beat.last |-> o_beat.valid
	) else $error("beat last without valid");

endmodule
